//--- hdl/decode_pkg.sv
package decode_pkg;

    //////////////////////////////////////////////////
    // instruction encodings
    //////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,                       // bgez / bltz by rt
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_COP0    = 6'b010000,                       // mfc0, mtc0, eret
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL   = 6'b000000,                         // also nop
        FN_SRL   = 6'b000010,
        FN_SRA   = 6'b000011,
        FN_SLLV  = 6'b000100,
        FN_SRLV  = 6'b000110,
        FN_SRAV  = 6'b000111,
        FN_JR    = 6'b001000,
        FN_JALR  = 6'b001001,
        FN_MFHI  = 6'b010000,
        FN_MTHI  = 6'b010001,
        FN_MFLO  = 6'b010010,
        FN_MTLO  = 6'b010011,
        FN_MULT  = 6'b011000,
        FN_MULTU = 6'b011001,
        FN_DIV   = 6'b011010,
        FN_DIVU  = 6'b011011,
        FN_ADD   = 6'b100000,
        FN_ADDU  = 6'b100001,
        FN_SUB   = 6'b100010,
        FN_SUBU  = 6'b100011,
        FN_AND   = 6'b100100,
        FN_OR    = 6'b100101,
        FN_XOR   = 6'b100110,
        FN_NOR   = 6'b100111,
        FN_SLT   = 6'b101010,
        FN_SLTU  = 6'b101011
    } funct_e;

    // r-type field split; imm is instr[15:0], index is instr[25:0]
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    //////////////////////////////////////////////////
    // stage control and data types
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        EXT_ZERO  = 2'd0,
        EXT_SIGN  = 2'd1,
        EXT_UPPER = 2'd2                              // imm << 16
    } ext_op_e;

    typedef enum logic [2:0] {
        NPC_SEQ    = 3'd0,
        NPC_BRANCH = 3'd1,
        NPC_JUMP   = 3'd2,
        NPC_JR     = 3'd3,
        NPC_ERET   = 3'd5
    } npc_sel_e;

    typedef enum logic [2:0] {
        FWD_RF       = 3'd0,
        FWD_EX_LINK  = 3'd1,
        FWD_ALU      = 3'd2,
        FWD_MEM_LINK = 3'd3,
        FWD_WB       = 3'd4
    } fwd_sel_e;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_RI = 5'd10;            // reserved instruction

    typedef struct packed {
        ext_op_e  ext_op;
        npc_sel_e npc_sel;
        logic     reserved;
    } decode_ctrl_t;

    typedef struct packed {
        logic [31:0] ex_link_pc;
        logic [31:0] ex_alu_result;
        logic [31:0] mem_link_pc;
        logic [31:0] wb_data;
    } fwd_bus_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_req_t;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file
(
    input  logic               clk,
    input  logic               reset,
    input  logic [4:0]         raddr_a,
    input  logic [4:0]         raddr_b,
    output logic [31:0]        rdata_a,
    output logic [31:0]        rdata_b,
    input  decode_pkg::wb_req_t wr
);

    logic [31:0] regs [0:31];                         // entry 0 never written

    // write port visible on reads from the next edge on
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr.en && (wr.addr != 5'd0))
        begin
            regs[wr.addr] <= wr.data;
        end
    end

    // read ports without write bypass
    assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_zero_read: assert property (
        @(posedge clk) disable iff (reset)
        ((raddr_a == 5'd0) |-> (rdata_a == 32'd0)) and
        ((raddr_b == 5'd0) |-> (rdata_b == 32'd0))
    ) else $error("reg_file: register 0 read back nonzero");

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
(
    input  decode_pkg::instr_t       instr,
    output decode_pkg::decode_ctrl_t ctrl
);

    localparam logic [5:0] ERET_FUNCT = 6'b011000;    // cop0 co-funct for eret

    //////////////////////////////////////////////////
    // opcode / funct classification
    //////////////////////////////////////////////////

    always_comb
    begin
        ctrl.ext_op   = decode_pkg::EXT_SIGN;
        ctrl.npc_sel  = decode_pkg::NPC_SEQ;
        ctrl.reserved = 1'b0;

        case (decode_pkg::opcode_e'(instr.opcode))
            decode_pkg::OP_ANDI,
            decode_pkg::OP_ORI,
            decode_pkg::OP_XORI:
                ctrl.ext_op = decode_pkg::EXT_ZERO;   // logical imm
            decode_pkg::OP_LUI:
                ctrl.ext_op = decode_pkg::EXT_UPPER;
            decode_pkg::OP_ADDI,
            decode_pkg::OP_ADDIU,
            decode_pkg::OP_SLTI,
            decode_pkg::OP_SLTIU,
            decode_pkg::OP_LB,
            decode_pkg::OP_LH,
            decode_pkg::OP_LW,
            decode_pkg::OP_LBU,
            decode_pkg::OP_LHU,
            decode_pkg::OP_SB,
            decode_pkg::OP_SH,
            decode_pkg::OP_SW:
                ctrl.ext_op = decode_pkg::EXT_SIGN;   // arith and addressing
            decode_pkg::OP_BEQ,
            decode_pkg::OP_BNE,
            decode_pkg::OP_REGIMM,
            decode_pkg::OP_BGTZ,
            decode_pkg::OP_BLEZ:
                ctrl.npc_sel = decode_pkg::NPC_BRANCH;
            decode_pkg::OP_J,
            decode_pkg::OP_JAL:
                ctrl.npc_sel = decode_pkg::NPC_JUMP;
            decode_pkg::OP_COP0:
            begin
                if (instr.funct == ERET_FUNCT)
                begin
                    ctrl.npc_sel = decode_pkg::NPC_ERET;
                end
            end
            decode_pkg::OP_SPECIAL:
            begin
                case (decode_pkg::funct_e'(instr.funct))
                    decode_pkg::FN_JR,
                    decode_pkg::FN_JALR:
                        ctrl.npc_sel = decode_pkg::NPC_JR;
                    decode_pkg::FN_SLL,
                    decode_pkg::FN_SRL,
                    decode_pkg::FN_SRA,
                    decode_pkg::FN_SLLV,
                    decode_pkg::FN_SRLV,
                    decode_pkg::FN_SRAV,
                    decode_pkg::FN_MFHI,
                    decode_pkg::FN_MTHI,
                    decode_pkg::FN_MFLO,
                    decode_pkg::FN_MTLO,
                    decode_pkg::FN_MULT,
                    decode_pkg::FN_MULTU,
                    decode_pkg::FN_DIV,
                    decode_pkg::FN_DIVU,
                    decode_pkg::FN_ADD,
                    decode_pkg::FN_ADDU,
                    decode_pkg::FN_SUB,
                    decode_pkg::FN_SUBU,
                    decode_pkg::FN_AND,
                    decode_pkg::FN_OR,
                    decode_pkg::FN_XOR,
                    decode_pkg::FN_NOR,
                    decode_pkg::FN_SLT,
                    decode_pkg::FN_SLTU:
                        ctrl.npc_sel = decode_pkg::NPC_SEQ;
                    default:
                        ctrl.reserved = 1'b1;         // unknown funct
                endcase
            end
            default:
                ctrl.reserved = 1'b1;                 // unknown opcode
        endcase
    end

    // an exception must not also redirect the pc
    always_comb
    begin
        if (ctrl.reserved)
        begin
            a_ri_seq: assert (ctrl.npc_sel == decode_pkg::NPC_SEQ)
                else $error("instr_decoder: reserved instruction with pc redirect");
        end
    end

endmodule

//--- hdl/operand_forward.sv
`timescale 1ns/1ps

module operand_forward
(
    input  logic [4:0]           reg_addr,
    input  logic [31:0]          reg_data,
    input  decode_pkg::fwd_sel_e sel,
    input  decode_pkg::fwd_bus_t fwd,
    output logic [31:0]          operand
);

    always_comb
    begin
        operand = 32'd0;                              // $zero wins over any select
        if (reg_addr != 5'd0)
        begin
            case (sel)
                decode_pkg::FWD_RF:
                    operand = reg_data;
                decode_pkg::FWD_EX_LINK:
                    operand = fwd.ex_link_pc;         // jal in execute
                decode_pkg::FWD_ALU:
                    operand = fwd.ex_alu_result;
                decode_pkg::FWD_MEM_LINK:
                    operand = fwd.mem_link_pc;        // jal in memory
                decode_pkg::FWD_WB:
                    operand = fwd.wb_data;
                default:
                    operand = 32'd0;
            endcase
        end
    end

    // hazard unit must only drive the five sources
    always_comb
    begin
        a_sel_legal: assert ($isunknown(sel) || (sel inside {decode_pkg::FWD_RF,
                                                             decode_pkg::FWD_EX_LINK,
                                                             decode_pkg::FWD_ALU,
                                                             decode_pkg::FWD_MEM_LINK,
                                                             decode_pkg::FWD_WB}))
            else $error("operand_forward: undefined forward select %0d", sel);
    end

endmodule

//--- hdl/imm_ext.sv
`timescale 1ns/1ps

module imm_ext
(
    input  decode_pkg::instr_t  instr,
    input  decode_pkg::ext_op_e ext_op,
    input  logic [31:0]         pc_plus4,
    output logic [31:0]         ext_imm,
    output logic [31:0]         branch_target,
    output logic [31:0]         jump_target
);

    logic [15:0] imm;
    logic [25:0] index;
    logic [31:0] sign_imm;

    assign imm      = instr[15:0];                    // overlays rd/shamt/funct
    assign index    = instr[25:0];
    assign sign_imm = {{16{imm[15]}}, imm};

    always_comb
    begin
        case (ext_op)
            decode_pkg::EXT_ZERO:
                ext_imm = {16'd0, imm};
            decode_pkg::EXT_UPPER:
                ext_imm = {imm, 16'd0};               // lui
            decode_pkg::EXT_SIGN:
                ext_imm = sign_imm;
            default:
                ext_imm = sign_imm;
        endcase
    end

    // word offset relative to the delay slot
    assign branch_target = pc_plus4 + {sign_imm[29:0], 2'b00};

    // region of the delay slot, 256 MB aligned
    assign jump_target = {pc_plus4[31:28], index, 2'b00};

endmodule

//--- hdl/branch_cmp.sv
`timescale 1ns/1ps

module branch_cmp
(
    input  decode_pkg::instr_t instr,
    input  logic [31:0]        operand_a,
    input  logic [31:0]        operand_b,
    output logic               taken
);

    localparam logic [4:0] RT_BLTZ = 5'd0;
    localparam logic [4:0] RT_BGEZ = 5'd1;

    logic signed [31:0] a_signed;

    assign a_signed = operand_a;

    always_comb
    begin
        taken = 1'b0;
        case (decode_pkg::opcode_e'(instr.opcode))
            decode_pkg::OP_BEQ:
                taken = (operand_a == operand_b);
            decode_pkg::OP_BNE:
                taken = (operand_a != operand_b);
            decode_pkg::OP_REGIMM:
            begin
                if (instr.rt == RT_BGEZ)
                begin
                    taken = (a_signed >= 32'sd0);
                end
                else if (instr.rt == RT_BLTZ)
                begin
                    taken = (a_signed < 32'sd0);
                end
            end
            decode_pkg::OP_BGTZ:
                taken = (a_signed > 32'sd0);
            decode_pkg::OP_BLEZ:
                taken = (a_signed <= 32'sd0);
            default:
                taken = 1'b0;                         // not a branch
        endcase
    end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
(
    input  logic                     clk,
    input  logic                     reset,
    input  decode_pkg::instr_t       instr,
    input  logic [31:0]              pc_plus4,
    input  decode_pkg::exc_code_t    exc_in,
    input  decode_pkg::wb_req_t      wb,
    input  decode_pkg::fwd_bus_t     fwd,
    input  decode_pkg::fwd_sel_e     fwd_sel_a,
    input  decode_pkg::fwd_sel_e     fwd_sel_b,
    output logic [4:0]               rs,
    output logic [4:0]               rt,
    output logic [4:0]               rd,
    output logic [31:0]              operand_a,
    output logic [31:0]              operand_b,
    output logic [31:0]              ext_imm,
    output logic [31:0]              branch_target,
    output logic [31:0]              jump_target,
    output logic [31:0]              jr_target,
    output decode_pkg::npc_sel_e     npc_sel,
    output logic                     branch_taken,
    output decode_pkg::exc_code_t    exc_out
);

    decode_pkg::decode_ctrl_t ctrl;
    logic [31:0]              rdata_a;
    logic [31:0]              rdata_b;

    assign rs = instr.rs;
    assign rt = instr.rt;
    assign rd = instr.rd;

    //////////////////////////////////////////////////
    // decode and register read
    //////////////////////////////////////////////////

    instr_decoder u_decoder
    (
        .instr (instr),
        .ctrl  (ctrl)
    );

    reg_file u_reg_file
    (
        .clk     (clk),
        .reset   (reset),
        .raddr_a (instr.rs),
        .raddr_b (instr.rt),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .wr      (wb)
    );

    operand_forward u_fwd_a
    (
        .reg_addr (instr.rs),
        .reg_data (rdata_a),
        .sel      (fwd_sel_a),
        .fwd      (fwd),
        .operand  (operand_a)
    );

    operand_forward u_fwd_b
    (
        .reg_addr (instr.rt),
        .reg_data (rdata_b),
        .sel      (fwd_sel_b),
        .fwd      (fwd),
        .operand  (operand_b)
    );

    //////////////////////////////////////////////////
    // targets and branch condition
    //////////////////////////////////////////////////

    imm_ext u_imm_ext
    (
        .instr         (instr),
        .ext_op        (ctrl.ext_op),
        .pc_plus4      (pc_plus4),
        .ext_imm       (ext_imm),
        .branch_target (branch_target),
        .jump_target   (jump_target)
    );

    branch_cmp u_branch_cmp
    (
        .instr     (instr),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .taken     (branch_taken)
    );

    assign jr_target = operand_a;                     // jr / jalr use forwarded rs
    assign npc_sel   = ctrl.npc_sel;

    // reserved instruction overrides the fetch exception
    assign exc_out = ctrl.reserved ? decode_pkg::EXC_RI : exc_in;

endmodule

//--- sim/tb_decode_tasks.svh
`ifndef TB_DECODE_TASKS_SVH
`define TB_DECODE_TASKS_SVH

//////////////////////////////////////////////////
// stimulus helpers
//////////////////////////////////////////////////

// taps 32 22 2 1 with one shift per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r          = {r[30:0], fb};
    end
    return r;
endfunction

function automatic decode_pkg::instr_t make_i(input decode_pkg::opcode_e op,
                                              input logic [4:0] rs_f, input logic [4:0] rt_f,
                                              input logic [15:0] imm);
    return decode_pkg::instr_t'({op, rs_f, rt_f, imm});
endfunction

function automatic decode_pkg::instr_t make_r(input logic [4:0] rs_f, input logic [4:0] rt_f,
                                              input logic [4:0] rd_f, input logic [5:0] funct);
    return decode_pkg::instr_t'({6'b000000, rs_f, rt_f, rd_f, 5'd0, funct});
endfunction

// drive point just after the rising edge
task automatic next_cycle;
    @(posedge clk);
    #1;
endtask

// outputs are stable mid-cycle
task automatic settle;
    #5;
endtask

//////////////////////////////////////////////////
// expected values
//////////////////////////////////////////////////

function automatic logic [31:0] expected_ext(input decode_pkg::opcode_e op,
                                             input logic [15:0] imm);
    case (op)
        decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_XORI:
            return {16'd0, imm};
        decode_pkg::OP_LUI:
            return {imm, 16'd0};
        default:
            return {{16{imm[15]}}, imm};
    endcase
endfunction

// kind 0 to 5 is beq bne bgez bltz bgtz blez
function automatic logic expected_taken(input int kind, input logic [31:0] a,
                                        input logic [31:0] b);
    case (kind)
        0:       return a == b;
        1:       return a != b;
        2:       return !a[31];
        3:       return a[31];
        4:       return !a[31] && (a != 32'd0);
        default: return a[31] || (a == 32'd0);
    endcase
endfunction

function automatic logic [31:0] expected_source(input decode_pkg::fwd_sel_e sel,
                                                input logic [31:0] reg_val);
    case (sel)
        decode_pkg::FWD_EX_LINK:  return fwd.ex_link_pc;
        decode_pkg::FWD_ALU:      return fwd.ex_alu_result;
        decode_pkg::FWD_MEM_LINK: return fwd.mem_link_pc;
        decode_pkg::FWD_WB:       return fwd.wb_data;
        default:                  return reg_val;
    endcase
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
        $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    end
endtask

task automatic check_npc(input string name, input decode_pkg::npc_sel_e exp,
                         input decode_pkg::npc_sel_e act);
    if (act !== exp)
    begin
        $display("Mismatch in %s: expected %s (%0d), actual %s (%0d)",
                 name, exp.name(), exp, act.name(), act);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    end
endtask

task automatic check_exc(input string name, input decode_pkg::exc_code_t exp,
                         input decode_pkg::exc_code_t act);
    if (act !== exp)
    begin
        $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    end
endtask

task automatic check_addr(input string name, input logic [4:0] exp, input logic [4:0] act);
    if (act !== exp)
    begin
        $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    end
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic test_regfile;
    logic [31:0] val;
    next_cycle();
    instr = '0;
    settle();
    check_npc("test_regfile nop", decode_pkg::NPC_SEQ, npc_sel);
    for (int i = 0; i < 32; i++)
    begin
        next_cycle();
        instr = make_r(i[4:0], i[4:0], 5'd0, decode_pkg::FN_ADDU);
        settle();
        check_word($sformatf("test_regfile reset r%0d a", i), 32'd0, operand_a);
        check_word($sformatf("test_regfile reset r%0d b", i), 32'd0, operand_b);
    end
    for (int i = 0; i < 32; i++)
    begin
        next_cycle();
        val     = rand_bits(32);
        wb.en   = 1'b1;
        wb.addr = i[4:0];
        wb.data = val;
        if (i != 0)
        begin
            shadow[i] = val;                          // r0 write is dropped
        end
    end
    next_cycle();
    wb = '0;
    for (int i = 0; i < 32; i++)
    begin
        next_cycle();
        instr = make_r(i[4:0], 5'(31 - i), 5'd0, decode_pkg::FN_ADDU);
        settle();
        check_word($sformatf("test_regfile r%0d", i), shadow[i], operand_a);
        check_word($sformatf("test_regfile r%0d", 31 - i), shadow[31 - i], operand_b);
    end
endtask

task automatic test_forwarding;
    decode_pkg::fwd_sel_e sa;
    decode_pkg::fwd_sel_e sb;
    next_cycle();
    fwd.ex_link_pc    = rand_bits(32);
    fwd.ex_alu_result = rand_bits(32);
    fwd.mem_link_pc   = rand_bits(32);
    fwd.wb_data       = rand_bits(32);
    for (int i = 0; i < 5; i++)
    begin
        for (int j = 0; j < 5; j++)
        begin
            next_cycle();
            sa        = decode_pkg::fwd_sel_e'(i[2:0]);
            sb        = decode_pkg::fwd_sel_e'(j[2:0]);
            fwd_sel_a = sa;
            fwd_sel_b = sb;
            instr     = make_r(5'd5, 5'd9, 5'd1, decode_pkg::FN_ADDU);
            settle();
            check_word($sformatf("test_forwarding a %s", sa.name()),
                       expected_source(sa, shadow[5]), operand_a);
            check_word($sformatf("test_forwarding b %s", sb.name()),
                       expected_source(sb, shadow[9]), operand_b);
        end
    end
    for (int i = 0; i < 5; i++)
    begin
        next_cycle();
        fwd_sel_a = decode_pkg::fwd_sel_e'(i[2:0]);
        fwd_sel_b = decode_pkg::fwd_sel_e'(i[2:0]);
        instr     = make_r(5'd0, 5'd0, 5'd1, decode_pkg::FN_ADDU);
        settle();
        check_word($sformatf("test_forwarding r0 a sel %0d", i), 32'd0, operand_a);
        check_word($sformatf("test_forwarding r0 b sel %0d", i), 32'd0, operand_b);
    end
endtask

task automatic test_extend;
    decode_pkg::opcode_e ops [7];
    logic [15:0]         imms [2];
    logic [31:0]         r;
    ops = '{decode_pkg::OP_ORI, decode_pkg::OP_ANDI, decode_pkg::OP_XORI, decode_pkg::OP_LUI,
            decode_pkg::OP_ADDI, decode_pkg::OP_LW, decode_pkg::OP_SW};
    r       = rand_bits(16);
    imms[0] = r[15:0] | 16'h8000;                     // top bit set
    r       = rand_bits(16);
    imms[1] = r[15:0] & 16'h7fff;
    for (int k = 0; k < 7; k++)
    begin
        for (int m = 0; m < 2; m++)
        begin
            next_cycle();
            instr = make_i(ops[k], 5'd3, 5'd4, imms[m]);
            settle();
            check_word($sformatf("test_extend %s imm %h", ops[k].name(), imms[m]),
                       expected_ext(ops[k], imms[m]), ext_imm);
        end
    end
endtask

task automatic test_branches;
    decode_pkg::opcode_e ops [6];
    logic [4:0]          rts [6];
    logic [31:0]         a_val [5];
    logic [31:0]         b_val [5];
    logic [31:0]         r;
    logic [15:0]         imm;
    ops = '{decode_pkg::OP_BEQ, decode_pkg::OP_BNE, decode_pkg::OP_REGIMM,
            decode_pkg::OP_REGIMM, decode_pkg::OP_BGTZ, decode_pkg::OP_BLEZ};
    rts      = '{5'd2, 5'd2, 5'd1, 5'd0, 5'd0, 5'd0}; // regimm rt picks bgez / bltz
    r        = rand_bits(32);
    a_val[0] = r;                                     // equal
    b_val[0] = r;
    a_val[1] = r;
    b_val[1] = r ^ 32'h0000_0100;
    a_val[2] = r | 32'h8000_0000;                     // negative
    b_val[2] = r;
    a_val[3] = 32'd0;
    b_val[3] = r;
    a_val[4] = (r & 32'h7fff_ffff) | 32'd1;           // positive
    b_val[4] = ~r;
    next_cycle();
    fwd_sel_a = decode_pkg::FWD_EX_LINK;
    fwd_sel_b = decode_pkg::FWD_ALU;
    for (int k = 0; k < 6; k++)
    begin
        for (int p = 0; p < 5; p++)
        begin
            next_cycle();
            r                 = rand_bits(16);
            imm               = r[15:0];
            r                 = rand_bits(32);
            pc_plus4          = {r[31:2], 2'b00};
            fwd.ex_link_pc    = a_val[p];
            fwd.ex_alu_result = b_val[p];
            instr             = make_i(ops[k], 5'd1, rts[k], imm);
            settle();
            check_bit($sformatf("test_branches kind %0d pair %0d", k, p),
                      expected_taken(k, a_val[p], b_val[p]), branch_taken);
            check_word($sformatf("test_branches target kind %0d", k),
                       pc_plus4 + {{14{imm[15]}}, imm, 2'b00}, branch_target);
            check_npc("test_branches npc", decode_pkg::NPC_BRANCH, npc_sel);
        end
    end
endtask

task automatic test_jumps;
    logic [31:0] r;
    for (int k = 0; k < 2; k++)
    begin
        next_cycle();
        r        = rand_bits(26);
        pc_plus4 = rand_bits(32);
        if (k == 0)
        begin
            instr = decode_pkg::instr_t'({decode_pkg::OP_J, r[25:0]});
        end
        else
        begin
            instr = decode_pkg::instr_t'({decode_pkg::OP_JAL, r[25:0]});
        end
        settle();
        check_word($sformatf("test_jumps target %0d", k), {pc_plus4[31:28], r[25:0], 2'b00},
                   jump_target);
        check_npc("test_jumps j npc", decode_pkg::NPC_JUMP, npc_sel);
    end
    next_cycle();
    fwd_sel_a = decode_pkg::FWD_RF;
    instr     = make_r(5'd7, 5'd0, 5'd0, decode_pkg::FN_JR);
    settle();
    check_word("test_jumps jr", shadow[7], jr_target);
    check_npc("test_jumps jr npc", decode_pkg::NPC_JR, npc_sel);
    next_cycle();
    fwd_sel_a   = decode_pkg::FWD_WB;                 // jalr with rs in writeback
    fwd.wb_data = rand_bits(32);
    instr       = make_r(5'd7, 5'd0, 5'd31, decode_pkg::FN_JALR);
    settle();
    check_word("test_jumps jalr", fwd.wb_data, jr_target);
    check_npc("test_jumps jalr npc", decode_pkg::NPC_JR, npc_sel);
    next_cycle();
    instr = decode_pkg::instr_t'(32'h4200_0018);      // eret
    settle();
    check_npc("test_jumps eret npc", decode_pkg::NPC_ERET, npc_sel);
endtask

task automatic test_reserved;
    next_cycle();
    exc_in = 5'd4;
    instr  = decode_pkg::instr_t'(32'hfc00_0000);     // opcode 111111 unused
    settle();
    check_exc("test_reserved opcode", 5'd10, exc_out);
    check_npc("test_reserved opcode npc", decode_pkg::NPC_SEQ, npc_sel);
    next_cycle();
    instr = make_r(5'd1, 5'd2, 5'd3, 6'b000001);      // funct 000001 unused
    settle();
    check_exc("test_reserved funct", 5'd10, exc_out);
    check_npc("test_reserved funct npc", decode_pkg::NPC_SEQ, npc_sel);
    check_addr("test_reserved rs field", 5'd1, rs);
    check_addr("test_reserved rt field", 5'd2, rt);
    check_addr("test_reserved rd field", 5'd3, rd);
    next_cycle();
    exc_in = 5'd7;
    instr  = make_i(decode_pkg::OP_ADDIU, 5'd1, 5'd2, 16'h1234);
    settle();
    check_exc("test_reserved legal", 5'd7, exc_out);
endtask

`endif

//--- sim/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

    localparam int NUM_STEPS = 192;                   // clock cycles used by all tests
    localparam int STEP_NS   = 20;
    localparam int MARGIN_NS = 200;

    logic                  clk;
    logic                  reset;
    decode_pkg::instr_t    instr;
    logic [31:0]           pc_plus4;
    decode_pkg::exc_code_t exc_in;
    decode_pkg::wb_req_t   wb;
    decode_pkg::fwd_bus_t  fwd;
    decode_pkg::fwd_sel_e  fwd_sel_a;
    decode_pkg::fwd_sel_e  fwd_sel_b;
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            rd;
    logic [31:0]           operand_a;
    logic [31:0]           operand_b;
    logic [31:0]           ext_imm;
    logic [31:0]           branch_target;
    logic [31:0]           jump_target;
    logic [31:0]           jr_target;
    decode_pkg::npc_sel_e  npc_sel;
    logic                  branch_taken;
    decode_pkg::exc_code_t exc_out;

    logic [31:0] shadow [0:31];                       // mirror of every register write
    logic [31:0] lfsr_state;

    `include "tb_decode_tasks.svh"

    decode_stage dut0
    (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .pc_plus4      (pc_plus4),
        .exc_in        (exc_in),
        .wb            (wb),
        .fwd           (fwd),
        .fwd_sel_a     (fwd_sel_a),
        .fwd_sel_b     (fwd_sel_b),
        .rs            (rs),
        .rt            (rt),
        .rd            (rd),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .ext_imm       (ext_imm),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .jr_target     (jr_target),
        .npc_sel       (npc_sel),
        .branch_taken  (branch_taken),
        .exc_out       (exc_out)
    );

    //////////////////////////////////////////////////
    // clock and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        #(NUM_STEPS * STEP_NS + MARGIN_NS);
        $display("watchdog: run did not finish within %0d ns", NUM_STEPS * STEP_NS + MARGIN_NS);
        $display("TESTS FAILED");
        $fatal(1, "simulation timed out");
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial
    begin
        lfsr_state = 32'h1fda;
        reset      = 1'b1;
        instr      = '0;                              // nop
        pc_plus4   = 32'd0;
        exc_in     = 5'd0;
        wb         = '0;
        fwd        = '0;
        fwd_sel_a  = decode_pkg::FWD_RF;
        fwd_sel_b  = decode_pkg::FWD_RF;
        for (int i = 0; i < 32; i++)
        begin
            shadow[i] = 32'd0;
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        test_regfile();
        test_forwarding();
        test_extend();
        test_branches();
        test_jumps();
        test_reserved();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+sim
hdl/decode_pkg.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/operand_forward.sv
hdl/imm_ext.sv
hdl/branch_cmp.sv
hdl/decode_stage.sv
sim/tb_decode_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_decode_stage \
    --Mdir obj_dir -o tb_decode_stage
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_decode_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
